/* compile.f */
+incdir+src
src/adc_cap_pkg.sv
src/adc_ddr_capture.sv
src/adc_fmt_offset.sv
src/adc_or_monitor.sv
src/adc_cap_top.sv
verif/adc_clk_gen.sv
verif/tb_adc_cap.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=tb_adc_cap

echo "building with verilator"
verilator --binary -j 0 -f compile.f --top-module tb_adc_cap --Mdir "$OBJ" -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

echo "running simulation"
"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
  echo "result: pass"
  exit 0
else
  echo "result: fail"
  exit 1
fi

/* src/adc_cap_params.svh */
// width and timing macros for the dual-channel ADC capture path
// widths are fixed here; the RTL carries no module parameters
`ifndef ADC_CAP_PARAMS_SVH
`define ADC_CAP_PARAMS_SVH

// sample width of one ADC channel, two's complement after processing
`define ADC_DW 16

// width of each per-channel over-range counter, saturates at all ones
`define ADC_ORC_W 16

// rising edges with rst_n high before adc_status goes high
// matches the pipeline depth from completing edge to adc_out
`define ADC_STATUS_DLY 4

// width of the status delay counter, must hold ADC_STATUS_DLY
`define ADC_STATUS_CW 3

`endif

/* src/adc_cap_pkg.sv */
// types shared by the capture path and its testbench
// ovr is the over-range bit that travels with each sample
`include "adc_cap_params.svh"

package adc_cap_pkg;

  // ****************************************
  // sample and pair
  // ****************************************

  // one channel sample, over-range bit on top
  typedef struct packed {
    logic                ovr;
    logic [`ADC_DW-1:0]  data;
  } adc_sample_t;

  // channel a sits in the upper half of the packed pair
  typedef struct packed {
    adc_sample_t  a;
    adc_sample_t  b;
  } adc_pair_t;

  // ****************************************
  // configuration
  // ****************************************

  // static levels from the processor side
  //   ddr_edgesel  1: a = rise word, b = following fall word
  //                0: a = fall word, b = next rise word
  //   fmt_twos     1: pins already two's complement
  //                0: pins are offset binary, msb gets inverted
  //   offset_x     signed dc offset subtracted per channel
  typedef struct packed {
    logic                ddr_edgesel;
    logic                fmt_twos;
    logic [`ADC_DW-1:0]  offset_a;
    logic [`ADC_DW-1:0]  offset_b;
  } adc_cfg_t;

endpackage

/* src/adc_cap_top.sv */
// dual-channel ddr adc capture, 4 rising edges from completing edge to adc_out
// cfg is treated as static, change it only with the stream flushed afterwards
`timescale 1ns/1ns
`include "adc_cap_params.svh"

module adc_cap_top (
  input  logic                    adc_clk,
  input  logic                    rst_n,
  // adc pins
  input  logic [`ADC_DW-1:0]      data_in_pins,
  input  logic                    or_in_pin,
  // processor levels and pulses
  input  adc_cap_pkg::adc_cfg_t   cfg,
  input  logic                    or_clr,
  // aligned, processed output pair
  output adc_cap_pkg::adc_pair_t  adc_out,
  // over-range monitoring, bit 0 of or_sticky is channel a
  output logic [1:0]              or_sticky,
  output logic [`ADC_ORC_W-1:0]   or_count_a,
  output logic [`ADC_ORC_W-1:0]   or_count_b,
  output logic                    adc_status
);

  // capture to processing, 2 cycles after the completing edge
  adc_cap_pkg::adc_pair_t raw_pair;

  // processing to monitor, 1 more cycle
  adc_cap_pkg::adc_pair_t proc_pair;

  // ****************************************
  // input side
  // ****************************************

  adc_ddr_capture i_capture (
    .adc_clk      (adc_clk),
    .rst_n        (rst_n),
    .data_in_pins (data_in_pins),
    .or_in_pin    (or_in_pin),
    .ddr_edgesel  (cfg.ddr_edgesel),
    .raw_pair     (raw_pair)
  );

  // ****************************************
  // format and offset
  // ****************************************

  adc_fmt_offset i_proc (
    .adc_clk   (adc_clk),
    .rst_n     (rst_n),
    .raw_pair  (raw_pair),
    .fmt_twos  (cfg.fmt_twos),
    .offset_a  (cfg.offset_a),
    .offset_b  (cfg.offset_b),
    .proc_pair (proc_pair)
  );

  // ****************************************
  // output side
  // ****************************************

  // last register stage, flags and counters track adc_out
  adc_or_monitor i_monitor (
    .adc_clk    (adc_clk),
    .rst_n      (rst_n),
    .proc_pair  (proc_pair),
    .or_clr     (or_clr),
    .adc_out    (adc_out),
    .or_sticky  (or_sticky),
    .or_count_a (or_count_a),
    .or_count_b (or_count_b),
    .adc_status (adc_status)
  );

endmodule

/* src/adc_ddr_capture.sv */
// pins are single-ended, sampled on both edges of adc_clk, no io delay
// pair k lands on raw_pair 2 rising edges after the edge that completes it
`timescale 1ns/1ns
`include "adc_cap_params.svh"

module adc_ddr_capture (
  input  logic                    adc_clk,
  input  logic                    rst_n,
  // ddr pin bus, over-range pin follows the same edges
  input  logic [`ADC_DW-1:0]      data_in_pins,
  input  logic                    or_in_pin,
  // pairing select, static level
  input  logic                    ddr_edgesel,
  output adc_cap_pkg::adc_pair_t  raw_pair
);

  // ****************************************
  // pin sampling
  // ****************************************

  // word on the pins at this instant, over-range alongside
  adc_cap_pkg::adc_sample_t pin_word;

  // falling edge capture, only register on the negative edge
  adc_cap_pkg::adc_sample_t fall_q;

  // rising edge capture and its one cycle delayed copy
  adc_cap_pkg::adc_sample_t rise_q;
  adc_cap_pkg::adc_sample_t rise_d;

  // fall word moved into the rising-edge domain
  adc_cap_pkg::adc_sample_t fall_r;

  // selected pair, then the output stage
  adc_cap_pkg::adc_pair_t   pair_q;

  assign pin_word = {or_in_pin, data_in_pins};

  // fall word F(k) of cycle k lands here half a cycle after rise word R(k)
  always_ff @(negedge adc_clk) begin
    fall_q <= pin_word;
  end

  // rising edge k+1 sees: rise_q <- R(k+1), rise_d <- R(k), fall_r <- F(k)
  // after this edge every word of pair k is in the rising domain
  always_ff @(posedge adc_clk) begin
    rise_q <= pin_word;
    rise_d <= rise_q;
    fall_r <= fall_q;
  end

  // ****************************************
  // pairing and re-alignment
  // ****************************************

  // edgesel=1: a = R(k), b = F(k), so the delayed rise copy is used
  // edgesel=0: a = F(k), b = R(k+1), rise word straight from rise_q
  // both settings complete on rising edge k+1
  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      pair_q <= '0;
    end else if (ddr_edgesel) begin
      pair_q.a <= rise_d;
      pair_q.b <= fall_r;
    end else begin
      pair_q.a <= fall_r;
      pair_q.b <= rise_q;
    end
  end

  // second rising stage, gives the fixed 2 cycle capture latency
  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      raw_pair <= '0;
    end else begin
      raw_pair <= pair_q;
    end
  end

endmodule

/* src/adc_fmt_offset.sv */
// offsets are signed two's complement, results saturate to the 16-bit range
// a saturated sample raises its over-range bit, same as the pin would
`timescale 1ns/1ns
`include "adc_cap_params.svh"

module adc_fmt_offset (
  input  logic                    adc_clk,
  input  logic                    rst_n,
  // aligned pair from the capture stage
  input  adc_cap_pkg::adc_pair_t  raw_pair,
  // format select and per-channel offsets
  input  logic                    fmt_twos,
  input  logic [`ADC_DW-1:0]      offset_a,
  input  logic [`ADC_DW-1:0]      offset_b,
  output adc_cap_pkg::adc_pair_t  proc_pair
);

  // ****************************************
  // per-channel processing
  // ****************************************

  // format fix, offset subtract, saturate, merge over-range
  function automatic adc_cap_pkg::adc_sample_t chan_proc(
    input adc_cap_pkg::adc_sample_t smp,
    input logic                     twos,
    input logic [`ADC_DW-1:0]       offs
  );
    logic [`ADC_DW-1:0]        val;
    logic [`ADC_DW:0]          diff;
    logic                      sat;
    adc_cap_pkg::adc_sample_t  res;

    // offset binary to two's complement is just an msb flip
    val = smp.data;
    if (!twos) begin
      val[`ADC_DW-1] = ~val[`ADC_DW-1];
    end

    // one guard bit, both operands sign extended
    diff = {val[`ADC_DW-1], val} - {offs[`ADC_DW-1], offs};

    // guard and msb disagree -> result left the 16-bit range
    sat = diff[`ADC_DW] ^ diff[`ADC_DW-1];

    if (sat) begin
      // guard bit tells the direction of the overflow
      if (diff[`ADC_DW]) begin
        res.data = {1'b1, {(`ADC_DW-1){1'b0}}};
      end else begin
        res.data = {1'b0, {(`ADC_DW-1){1'b1}}};
      end
    end else begin
      res.data = diff[`ADC_DW-1:0];
    end

    // pin over-range or saturation both count
    res.ovr = smp.ovr | sat;
    return res;
  endfunction

  // combinational results for both channels
  adc_cap_pkg::adc_sample_t proc_a;
  adc_cap_pkg::adc_sample_t proc_b;

  assign proc_a = chan_proc(raw_pair.a, fmt_twos, offset_a);
  assign proc_b = chan_proc(raw_pair.b, fmt_twos, offset_b);

  // ****************************************
  // output register
  // ****************************************

  // single cycle through this block
  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      proc_pair <= '0;
    end else begin
      proc_pair.a <= proc_a;
      proc_pair.b <= proc_b;
    end
  end

endmodule

/* src/adc_or_monitor.sv */
// or_sticky bit 0 is channel a, bit 1 is channel b; counters clear on reset only
// adc_status is a level that rises once after reset and then holds
`timescale 1ns/1ns
`include "adc_cap_params.svh"

module adc_or_monitor (
  input  logic                    adc_clk,
  input  logic                    rst_n,
  // processed pair, one new pair every cycle
  input  adc_cap_pkg::adc_pair_t  proc_pair,
  // single cycle pulse, clears both sticky flags
  input  logic                    or_clr,
  output adc_cap_pkg::adc_pair_t  adc_out,
  output logic [1:0]              or_sticky,
  output logic [`ADC_ORC_W-1:0]   or_count_a,
  output logic [`ADC_ORC_W-1:0]   or_count_b,
  output logic                    adc_status
);

  // over-range hits of the pair entering adc_out this cycle
  logic [1:0]                 ovr_hit;

  // cycles since reset release, stops at the delay value
  logic [`ADC_STATUS_CW-1:0]  status_cnt;

  assign ovr_hit = {proc_pair.b.ovr, proc_pair.a.ovr};

  // saturating increment
  function automatic logic [`ADC_ORC_W-1:0] cnt_next(
    input logic [`ADC_ORC_W-1:0] cnt,
    input logic                  hit
  );
    if (hit && (cnt != {`ADC_ORC_W{1'b1}})) begin
      return cnt + 1'b1;
    end
    return cnt;
  endfunction

  // ****************************************
  // output register and sticky flags
  // ****************************************

  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      adc_out   <= '0;
      or_sticky <= 2'b00;
    end else begin
      adc_out <= proc_pair;
      // clear drops old state, a new hit in the same cycle still sets the flag
      if (or_clr) begin
        or_sticky <= ovr_hit;
      end else begin
        or_sticky <= or_sticky | ovr_hit;
      end
    end
  end

  // ****************************************
  // over-range counters
  // ****************************************

  // one count per cycle with the channel's over-range bit set
  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      or_count_a <= '0;
      or_count_b <= '0;
    end else begin
      or_count_a <= cnt_next(or_count_a, ovr_hit[0]);
      or_count_b <= cnt_next(or_count_b, ovr_hit[1]);
    end
  end

  // ****************************************
  // status
  // ****************************************

  // counts rising edges with rst_n high until the pipeline is full
  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      status_cnt <= '0;
    end else if (status_cnt != `ADC_STATUS_CW'(`ADC_STATUS_DLY)) begin
      status_cnt <= status_cnt + 1'b1;
    end
  end

  // high after ADC_STATUS_DLY edges, holds until the next reset
  assign adc_status = (status_cnt == `ADC_STATUS_CW'(`ADC_STATUS_DLY));

endmodule

/* verif/adc_clk_gen.sv */
// free-running 20 ns clock, reset low for the first 3 rising edges
// reset release lands 2 ns after the third edge
`timescale 1ns/1ns

module adc_clk_gen (
  output logic adc_clk,
  output logic rst_n
);

  // 10 ns half period
  initial begin
    adc_clk = 1'b0;
    forever #10 adc_clk = ~adc_clk;
  end

  // first edge with rst_n high is the fourth rising edge
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge adc_clk);
    #2;
    rst_n = 1'b1;
  end

endmodule

/* verif/tb_adc_cap.sv */
// random ddr stimulus from a fixed seed, checked against an edge-accurate model
// outputs are compared at the falling edge where they are stable
`timescale 1ns/1ns
`include "adc_cap_params.svh"

module tb_adc_cap;

  localparam int HIST    = 4096;
  localparam int CNT_MAX = (1 << `ADC_ORC_W) - 1;

  logic                    adc_clk;
  logic                    rst_n;
  logic [`ADC_DW-1:0]      data_in_pins;
  logic                    or_in_pin;
  adc_cap_pkg::adc_cfg_t   cfg;
  logic                    or_clr;
  adc_cap_pkg::adc_pair_t  adc_out;
  logic [1:0]              or_sticky;
  logic [`ADC_ORC_W-1:0]   or_count_a;
  logic [`ADC_ORC_W-1:0]   or_count_b;
  logic                    adc_status;

  // words seen on the pins at each edge, plus cfg and clear at each rising edge
  adc_cap_pkg::adc_sample_t rise_w [0:HIST-1];
  adc_cap_pkg::adc_sample_t fall_w [0:HIST-1];
  adc_cap_pkg::adc_cfg_t    cfg_h  [0:HIST-1];
  logic                     clr_h  [0:HIST-1];

  integer                 seed;
  int                     errors;
  int                     cyc;
  adc_cap_pkg::adc_cfg_t  next_cfg;
  logic                   next_clr;
  logic                   or_en;
  logic                   extreme_en;
  logic                   status_up;
  logic [1:0]             sticky_m;
  int                     cnt_a_m;
  int                     cnt_b_m;

  adc_clk_gen i_clk_gen (
    .adc_clk (adc_clk),
    .rst_n   (rst_n)
  );

  adc_cap_top i_dut (
    .adc_clk      (adc_clk),
    .rst_n        (rst_n),
    .data_in_pins (data_in_pins),
    .or_in_pin    (or_in_pin),
    .cfg          (cfg),
    .or_clr       (or_clr),
    .adc_out      (adc_out),
    .or_sticky    (or_sticky),
    .or_count_a   (or_count_a),
    .or_count_b   (or_count_b),
    .adc_status   (adc_status)
  );

  // ****************************************
  // compare tasks
  // ****************************************

  task automatic check_pair(input adc_cap_pkg::adc_pair_t got,
                            input adc_cap_pkg::adc_pair_t exp_p);
    if (got !== exp_p) begin
      errors++;
      $display("ERROR @%0t: adc_out got %h expected %h (cycle %0d)", $time, got, exp_p, cyc);
    end
  endtask

  task automatic check_flags(input logic [1:0] got, input logic [1:0] exp_f);
    if (got !== exp_f) begin
      errors++;
      $display("ERROR @%0t: or_sticky got %b expected %b", $time, got, exp_f);
    end
  endtask

  task automatic check_count(input logic [`ADC_ORC_W-1:0] got,
                             input logic [`ADC_ORC_W-1:0] exp_c,
                             input string                 what);
    if (got !== exp_c) begin
      errors++;
      $display("ERROR @%0t: %s got %0d expected %0d", $time, what, got, exp_c);
    end
  endtask

  task automatic check_level(input logic got, input logic exp_l, input string what);
    if (got !== exp_l) begin
      errors++;
      $display("ERROR @%0t: %s got %b expected %b", $time, what, got, exp_l);
    end
  endtask

  // ****************************************
  // reference model
  // ****************************************

  // msb flip for offset binary, signed subtract, clamp to 16 bits
  function automatic adc_cap_pkg::adc_sample_t process_sample(
    input adc_cap_pkg::adc_sample_t smp,
    input logic                     twos,
    input logic [`ADC_DW-1:0]       offs
  );
    logic signed [`ADC_DW-1:0]  sv;
    logic signed [`ADC_DW-1:0]  so;
    int                         d;
    logic                       sat;
    adc_cap_pkg::adc_sample_t   res;

    sv = twos ? smp.data : (smp.data ^ 16'h8000);
    so = offs;
    d = int'(sv) - int'(so);
    sat = 1'b0;
    if (d > 32767) begin
      d = 32767;
      sat = 1'b1;
    end else if (d < -32768) begin
      d = -32768;
      sat = 1'b1;
    end
    res.data = d[`ADC_DW-1:0];
    res.ovr = smp.ovr | sat;
    return res;
  endfunction

  // pair k leaves at edge k+5; pairing chosen at edge n-3, processing at edge n-1
  function automatic adc_cap_pkg::adc_pair_t expected_out(input int n);
    adc_cap_pkg::adc_cfg_t   sel_cfg;
    adc_cap_pkg::adc_cfg_t   prc_cfg;
    adc_cap_pkg::adc_pair_t  raw;
    adc_cap_pkg::adc_pair_t  res;
    int                      k;

    sel_cfg = cfg_h[n-3];
    prc_cfg = cfg_h[n-1];
    k = n - 5;
    if (sel_cfg.ddr_edgesel) begin
      raw.a = rise_w[k];
      raw.b = fall_w[k];
    end else begin
      raw.a = fall_w[k];
      raw.b = rise_w[k+1];
    end
    res.a = process_sample(raw.a, prc_cfg.fmt_twos, prc_cfg.offset_a);
    res.b = process_sample(raw.b, prc_cfg.fmt_twos, prc_cfg.offset_b);
    return res;
  endfunction

  // ****************************************
  // stimulus
  // ****************************************

  function automatic adc_cap_pkg::adc_sample_t gen_word();
    logic [31:0]               rnd;
    adc_cap_pkg::adc_sample_t  w;

    rnd = $random(seed);
    w.data = rnd[15:0];
    if (extreme_en) begin
      case (rnd[18:16])
        3'd0:    w.data = 16'h7FFF;
        3'd1:    w.data = 16'h8000;
        3'd2:    w.data = 16'h7FF0;
        3'd3:    w.data = 16'h800F;
        default: w.data = rnd[15:0];
      endcase
    end
    w.ovr = or_en && (rnd[22:20] == 3'd0);
    return w;
  endfunction

  function automatic logic [`ADC_DW-1:0] rand_offset();
    logic [31:0] rnd;

    rnd = $random(seed);
    if (rnd[17:16] == 2'd0) begin
      return rnd[18] ? 16'h7FFF : 16'h8000;
    end
    return rnd[15:0];
  endfunction

  task automatic drive_word(input adc_cap_pkg::adc_sample_t w);
    data_in_pins = w.data;
    or_in_pin = w.ovr;
  endtask

  // one adc_clk period with recording, fall word, negedge checks and the next rise word
  task automatic run_cycle();
    adc_cap_pkg::adc_pair_t  exp_p;
    logic [1:0]              hit;

    @(posedge adc_clk);
    rise_w[cyc] = {or_in_pin, data_in_pins};
    cfg_h[cyc] = cfg;
    clr_h[cyc] = or_clr;
    #2;
    cfg = next_cfg;
    or_clr = next_clr;
    next_clr = 1'b0;
    drive_word(gen_word());
    @(negedge adc_clk);
    fall_w[cyc] = {or_in_pin, data_in_pins};
    // pipeline holds real pairs from edge 6 on
    if (cyc >= 6) begin
      exp_p = expected_out(cyc);
      hit = {exp_p.b.ovr, exp_p.a.ovr};
      if (clr_h[cyc]) begin
        sticky_m = hit;
      end else begin
        sticky_m = sticky_m | hit;
      end
      if (hit[0] && cnt_a_m < CNT_MAX) begin
        cnt_a_m++;
      end
      if (hit[1] && cnt_b_m < CNT_MAX) begin
        cnt_b_m++;
      end
      check_pair(adc_out, exp_p);
    end
    check_flags(or_sticky, sticky_m);
    check_count(or_count_a, cnt_a_m[`ADC_ORC_W-1:0], "or_count_a");
    check_count(or_count_b, cnt_b_m[`ADC_ORC_W-1:0], "or_count_b");
    if (status_up) begin
      check_level(adc_status, 1'b1, "adc_status held");
    end
    #2;
    drive_word(gen_word());
    cyc++;
  endtask

  task automatic run_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      run_cycle();
    end
  endtask

  task automatic run_all();
    // pairing in both edge settings, two's complement, zero offsets
    run_cycles(200);
    next_cfg.ddr_edgesel = 1'b0;
    run_cycles(8);
    run_cycles(200);
    // offset binary input
    next_cfg.fmt_twos = 1'b0;
    run_cycles(8);
    run_cycles(200);
    // random offsets against near-extreme samples
    next_cfg.fmt_twos = 1'b1;
    extreme_en = 1'b1;
    for (int j = 0; j < 6; j++) begin
      next_cfg.offset_a = rand_offset();
      next_cfg.offset_b = rand_offset();
      next_cfg.ddr_edgesel = j[0];
      run_cycles(8);
      run_cycles(50);
    end
    // pin over-range with random clear pulses
    or_en = 1'b1;
    for (int j = 0; j < 300; j++) begin
      if (($random(seed) & 15) == 0) begin
        next_clr = 1'b1;
      end
      run_cycle();
    end
    // quiet stream and then a clear that must drop both flags
    or_en = 1'b0;
    extreme_en = 1'b0;
    next_cfg.offset_a = '0;
    next_cfg.offset_b = '0;
    run_cycles(8);
    next_clr = 1'b1;
    run_cycles(4);
    check_flags(or_sticky, 2'b00);
  endtask

  // ****************************************
  // main sequence
  // ****************************************

  initial begin
    int wait_cnt;

    seed = 81237;
    errors = 0;
    cyc = 0;
    or_en = 1'b0;
    extreme_en = 1'b0;
    status_up = 1'b0;
    sticky_m = 2'b00;
    cnt_a_m = 0;
    cnt_b_m = 0;
    next_clr = 1'b0;
    next_cfg = '0;
    next_cfg.ddr_edgesel = 1'b1;
    next_cfg.fmt_twos = 1'b1;
    cfg = next_cfg;
    or_clr = 1'b0;
    drive_word(gen_word());

    // 3 reset edges, then status stays low until the last of its delay edges
    for (int i = 0; i < 3 + `ADC_STATUS_DLY - 1; i++) begin
      run_cycle();
      check_level(adc_status, 1'b0, "adc_status after reset");
    end

    wait_cnt = 0;
    while (!adc_status && wait_cnt < 20) begin
      run_cycle();
      wait_cnt++;
    end

    if (!adc_status) begin
      errors++;
      $display("adc_status never rose within 20 cycles after reset");
      $display("errors: %0d", errors);
      $display("SOME TESTS FAILED");
      $finish;
    end else begin
      status_up = 1'b1;
      run_all();
      $display("errors: %0d, cycles run: %0d", errors, cyc);
      if (errors == 0) begin
        $display("ALL TESTS PASSED");
      end else begin
        $display("SOME TESTS FAILED");
      end
      $finish;
    end
  end

  // whole-run limit far above the normal run length
  initial begin
    #1000000;
    $display("simulation timed out before the test sequence finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
